// File: Bender.yml
package:
  name: cpu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - instr_decode.sv
      - alu_unit.sv
      - mul_pipe.sv
      - writeback_regs.sv
      - cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv

// File: alu_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module alu_unit (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      alu_valid_i,
  input  cpu_pkg::alu_req_t         alu_req_i,
  output logic                      alu_done_o,
  output logic [`CPU_REG_IDX_W-1:0] alu_rd_o,
  output logic [`CPU_DATA_W-1:0]    alu_result_o
);
  import cpu_pkg::*;

  logic                   alu_valid_q;
  alu_req_t               req_q;
  logic [4:0]             shamt;
  logic [`CPU_DATA_W-1:0] result;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_valid_q <= 1'b0;
    end else begin
      alu_valid_q <= alu_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_valid_i) begin
      req_q <= alu_req_i;
    end
  end

  // Only the low five bits shift
  assign shamt = req_q.b[4:0];

  always_comb begin
    case (req_q.op)
      OP_ADD:  result = req_q.a + req_q.b;
      OP_SUB:  result = req_q.a - req_q.b;
      OP_AND:  result = req_q.a & req_q.b;
      OP_OR:   result = req_q.a | req_q.b;
      OP_XOR:  result = req_q.a ^ req_q.b;
      OP_SLL:  result = req_q.a << shamt;
      OP_SRL:  result = req_q.a >> shamt;
      OP_SLT:  result = {{(`CPU_DATA_W-1){1'b0}}, $signed(req_q.a) < $signed(req_q.b)};
      OP_ADDI: result = req_q.a + req_q.imm;
      default: result = '0;
    endcase
  end

  assign alu_done_o   = alu_valid_q;
  assign alu_rd_o     = req_q.rd;
  assign alu_result_o = result;

endmodule

`default_nettype wire

// File: cpu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module cpu (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      instr_valid_i,
  input  logic [`CPU_INSTR_W-1:0]   instr_i,
  output logic                      stall_o,
  output logic                      wb_valid_o,
  output logic [`CPU_REG_IDX_W-1:0] wb_reg_o,
  output logic [`CPU_DATA_W-1:0]    wb_data_o
);
  import cpu_pkg::*;

  // Decode to execute
  logic                      alu_valid;
  alu_req_t                  alu_req;
  logic                      mul_valid;
  logic [`CPU_REG_IDX_W-1:0] mul_rd_in;
  logic [`CPU_DATA_W-1:0]    mul_a;
  logic [`CPU_DATA_W-1:0]    mul_b;

  // Register file read port
  logic [`CPU_REG_IDX_W-1:0] rs1_idx;
  logic [`CPU_REG_IDX_W-1:0] rs2_idx;
  logic [`CPU_DATA_W-1:0]    rs1_data;
  logic [`CPU_DATA_W-1:0]    rs2_data;

  // Execute results and hazard feedback
  logic                      alu_done;
  logic [`CPU_REG_IDX_W-1:0] alu_rd;
  logic [`CPU_DATA_W-1:0]    alu_result;
  logic                      mul_done;
  logic [`CPU_REG_IDX_W-1:0] mul_rd_out;
  logic [`CPU_DATA_W-1:0]    mul_result;
  logic [`CPU_NUM_REGS-1:0]  mul_pending;
  logic                      mul_wb_next;

  instr_decode i_instr_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .mul_pending_i (mul_pending),
    .mul_wb_next_i (mul_wb_next),
    .stall_o       (stall_o),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .alu_valid_o   (alu_valid),
    .alu_req_o     (alu_req),
    .mul_valid_o   (mul_valid),
    .mul_rd_o      (mul_rd_in),
    .mul_a_o       (mul_a),
    .mul_b_o       (mul_b)
  );

  alu_unit i_alu_unit (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .alu_valid_i  (alu_valid),
    .alu_req_i    (alu_req),
    .alu_done_o   (alu_done),
    .alu_rd_o     (alu_rd),
    .alu_result_o (alu_result)
  );

  mul_pipe i_mul_pipe (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .mul_valid_i   (mul_valid),
    .mul_rd_i      (mul_rd_in),
    .mul_a_i       (mul_a),
    .mul_b_i       (mul_b),
    .mul_done_o    (mul_done),
    .mul_rd_o      (mul_rd_out),
    .mul_result_o  (mul_result),
    .mul_pending_o (mul_pending),
    .mul_wb_next_o (mul_wb_next)
  );

  writeback_regs i_writeback_regs (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rs1_idx_i    (rs1_idx),
    .rs2_idx_i    (rs2_idx),
    .alu_done_i   (alu_done),
    .alu_rd_i     (alu_rd),
    .alu_result_i (alu_result),
    .mul_done_i   (mul_done),
    .mul_rd_i     (mul_rd_out),
    .mul_result_i (mul_result),
    .rs1_data_o   (rs1_data),
    .rs2_data_o   (rs2_data),
    .wb_valid_o   (wb_valid_o),
    .wb_reg_o     (wb_reg_o),
    .wb_data_o    (wb_data_o)
  );

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

  // Internal opcodes after decode
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLL  = 4'd6,
    OP_SRL  = 4'd7,
    OP_SLT  = 4'd8,
    OP_ADDI = 4'd9,
    OP_MUL  = 4'd10
  } op_t;

  // Request handed from decode to the ALU stage
  typedef struct packed {
    op_t                       op;
    logic [`CPU_REG_IDX_W-1:0] rd;
    logic [`CPU_DATA_W-1:0]    a;
    logic [`CPU_DATA_W-1:0]    b;
    logic [`CPU_DATA_W-1:0]    imm;
  } alu_req_t;

endpackage

`default_nettype wire

// File: cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and register width
`define CPU_DATA_W 32

// Architectural register file
`define CPU_NUM_REGS 32
`define CPU_REG_IDX_W 5

// Instruction word width, RV32 encodings
`define CPU_INSTR_W 32

// Multiply pipeline depth, stage 1 to stage 5
`define CPU_MUL_STAGES 5

`endif

// File: flist.f
+incdir+.
cpu_pkg.sv
instr_decode.sv
alu_unit.sv
mul_pipe.sv
writeback_regs.sv
cpu.sv
tb_cpu.sv

// File: instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module instr_decode (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       instr_valid_i,
  input  logic [`CPU_INSTR_W-1:0]    instr_i,
  input  logic [`CPU_DATA_W-1:0]     rs1_data_i,
  input  logic [`CPU_DATA_W-1:0]     rs2_data_i,
  input  logic [`CPU_NUM_REGS-1:0]   mul_pending_i,
  input  logic                       mul_wb_next_i,
  output logic                       stall_o,
  output logic [`CPU_REG_IDX_W-1:0]  rs1_idx_o,
  output logic [`CPU_REG_IDX_W-1:0]  rs2_idx_o,
  output logic                       alu_valid_o,
  output cpu_pkg::alu_req_t          alu_req_o,
  output logic                       mul_valid_o,
  output logic [`CPU_REG_IDX_W-1:0]  mul_rd_o,
  output logic [`CPU_DATA_W-1:0]     mul_a_o,
  output logic [`CPU_DATA_W-1:0]     mul_b_o
);
  import cpu_pkg::*;

  // RV32 major opcodes and funct7 values
  localparam logic [6:0] OPC_REG   = 7'b0110011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  logic                      dec_valid_q;
  logic [`CPU_INSTR_W-1:0]   dec_instr_q;
  logic [6:0]                opcode;
  logic [6:0]                funct7;
  logic [2:0]                funct3;
  logic [`CPU_REG_IDX_W-1:0] rd;
  logic [`CPU_REG_IDX_W-1:0] rs1;
  logic [`CPU_REG_IDX_W-1:0] rs2;
  logic [`CPU_DATA_W-1:0]    imm;
  op_t                       op;
  logic                      uses_rs2;
  logic                      is_mul;
  logic                      src_hazard;
  logic                      dst_hazard;
  logic                      wb_hazard;
  logic                      issue;

  // Decode register, held while the instruction is blocked
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      dec_valid_q <= 1'b0;
    end else if (!stall_o) begin
      dec_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_o && instr_valid_i) begin
      dec_instr_q <= instr_i;
    end
  end

  assign opcode = dec_instr_q[6:0];
  assign rd     = dec_instr_q[11:7];
  assign funct3 = dec_instr_q[14:12];
  assign rs1    = dec_instr_q[19:15];
  assign rs2    = dec_instr_q[24:20];
  assign funct7 = dec_instr_q[31:25];
  assign imm    = {{(`CPU_DATA_W-12){dec_instr_q[31]}}, dec_instr_q[31:20]};

  always_comb begin
    op       = OP_NONE;
    uses_rs2 = 1'b0;
    case (opcode)
      OPC_REG: begin
        uses_rs2 = 1'b1;
        if (funct7 == F7_BASE) begin
          case (funct3)
            3'b000:  op = OP_ADD;
            3'b001:  op = OP_SLL;
            3'b010:  op = OP_SLT;
            3'b100:  op = OP_XOR;
            3'b101:  op = OP_SRL;
            3'b110:  op = OP_OR;
            3'b111:  op = OP_AND;
            default: op = OP_NONE;
          endcase
        end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
          op = OP_SUB;
        end else if (funct7 == F7_MULDIV && funct3 == 3'b000) begin
          op = OP_MUL;
        end
      end
      OPC_IMM: begin
        if (funct3 == 3'b000) begin
          op = OP_ADDI;
        end
      end
      default: op = OP_NONE;
    endcase
    // Writes to x0 retire as no-ops
    if (rd == '0) begin
      op = OP_NONE;
    end
  end

  assign is_mul = (op == OP_MUL);

  // Hazards against multiplies still in stages 1 to 4
  assign src_hazard = (rs1 != '0 && mul_pending_i[rs1]) ||
                      (uses_rs2 && rs2 != '0 && mul_pending_i[rs2]);
  assign dst_hazard = mul_pending_i[rd];
  // ALU result would land together with the stage 5 multiply
  assign wb_hazard  = !is_mul && mul_wb_next_i;

  assign stall_o = dec_valid_q && (op != OP_NONE) && (src_hazard || dst_hazard || wb_hazard);
  assign issue   = dec_valid_q && (op != OP_NONE) && !stall_o;

  assign rs1_idx_o = rs1;
  assign rs2_idx_o = rs2;

  assign alu_valid_o = issue && !is_mul;
  assign alu_req_o   = '{op: op, rd: rd, a: rs1_data_i, b: rs2_data_i, imm: imm};

  assign mul_valid_o = issue && is_mul;
  assign mul_rd_o    = rd;
  assign mul_a_o     = rs1_data_i;
  assign mul_b_o     = rs2_data_i;

endmodule

`default_nettype wire

// File: mul_pipe.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module mul_pipe (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      mul_valid_i,
  input  logic [`CPU_REG_IDX_W-1:0] mul_rd_i,
  input  logic [`CPU_DATA_W-1:0]    mul_a_i,
  input  logic [`CPU_DATA_W-1:0]    mul_b_i,
  output logic                      mul_done_o,
  output logic [`CPU_REG_IDX_W-1:0] mul_rd_o,
  output logic [`CPU_DATA_W-1:0]    mul_result_o,
  output logic [`CPU_NUM_REGS-1:0]  mul_pending_o,
  output logic                      mul_wb_next_o
);

  localparam int HALF_W = `CPU_DATA_W / 2;

  logic [`CPU_MUL_STAGES-1:0] vld_q;
  logic [`CPU_REG_IDX_W-1:0]  rd_q [`CPU_MUL_STAGES];
  logic [`CPU_DATA_W-1:0]     a_q;
  logic [`CPU_DATA_W-1:0]     b_q;
  logic [`CPU_DATA_W-1:0]     pp_ll_q;
  logic [HALF_W-1:0]          pp_lh_q;
  logic [HALF_W-1:0]          pp_hl_q;
  logic [`CPU_DATA_W-1:0]     al_ll_q;
  logic [`CPU_DATA_W-1:0]     al_lh_q;
  logic [`CPU_DATA_W-1:0]     al_hl_q;
  logic [`CPU_DATA_W-1:0]     sum_q;
  logic [`CPU_DATA_W-1:0]     res_q;

  // Valid bits march one stage per cycle, never stalled
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[`CPU_MUL_STAGES-2:0], mul_valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q[0] <= mul_rd_i;
    for (int s = 1; s < `CPU_MUL_STAGES; s++) begin
      rd_q[s] <= rd_q[s-1];
    end
    a_q <= mul_a_i;
    b_q <= mul_b_i;
    // hi*hi only reaches bits above the low word
    pp_ll_q <= a_q[HALF_W-1:0] * b_q[HALF_W-1:0];
    pp_lh_q <= a_q[HALF_W-1:0] * b_q[`CPU_DATA_W-1:HALF_W];
    pp_hl_q <= a_q[`CPU_DATA_W-1:HALF_W] * b_q[HALF_W-1:0];
    al_ll_q <= pp_ll_q;
    al_lh_q <= {pp_lh_q, {HALF_W{1'b0}}};
    al_hl_q <= {pp_hl_q, {HALF_W{1'b0}}};
    sum_q   <= al_ll_q + al_lh_q + al_hl_q;
    res_q   <= sum_q;
  end

  // Destinations in stages 1 to 4
  always_comb begin
    mul_pending_o = '0;
    for (int s = 0; s < `CPU_MUL_STAGES - 1; s++) begin
      if (vld_q[s]) begin
        mul_pending_o[rd_q[s]] = 1'b1;
      end
    end
  end

  assign mul_wb_next_o = vld_q[`CPU_MUL_STAGES-2];
  assign mul_done_o    = vld_q[`CPU_MUL_STAGES-1];
  assign mul_rd_o      = rd_q[`CPU_MUL_STAGES-1];
  assign mul_result_o  = res_q;

endmodule

`default_nettype wire

// File: tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu;

  localparam int CLK_PERIOD   = 100;
  localparam int STIM_DLY     = 10;
  localparam int RST_CYCLES   = 4;
  localparam int NUM_INSTR    = 600;
  localparam int QDEPTH       = 1024;
  localparam int WDOG_CYCLES  = NUM_INSTR * (`CPU_MUL_STAGES * 4) + 200;
  localparam int DRAIN_CYCLES = `CPU_MUL_STAGES * 4;

  logic                      clk_i = 1'b0;
  logic                      rst_i;
  logic                      instr_valid_i;
  logic [`CPU_INSTR_W-1:0]   instr_i;
  logic                      stall_o;
  logic                      wb_valid_o;
  logic [`CPU_REG_IDX_W-1:0] wb_reg_o;
  logic [`CPU_DATA_W-1:0]    wb_data_o;

  integer seed;
  int     value_errors;
  int     other_errors;
  int     pulses;
  int     expected_writes;
  int     outstanding;
  int     offered;
  int     post_rst_cycles;
  logic   taken;

  // Reference register file and per-register FIFOs of expected writes
  logic [`CPU_DATA_W-1:0] model_regs [`CPU_NUM_REGS];
  logic [`CPU_DATA_W-1:0] exp_mem [`CPU_NUM_REGS][QDEPTH];
  int                     q_head [`CPU_NUM_REGS];
  int                     q_tail [`CPU_NUM_REGS];

  cpu i_cpu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .stall_o       (stall_o),
    .wb_valid_o    (wb_valid_o),
    .wb_reg_o      (wb_reg_o),
    .wb_data_o     (wb_data_o)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Mostly x0 to x7 so hazards show up often
  function automatic logic [4:0] pick_reg(input logic [31:0] r);
    if (r[1:0] != 2'b00) begin
      pick_reg = {2'b00, r[4:2]};
    end else begin
      pick_reg = r[9:5];
    end
  endfunction

  task automatic make_instr(output logic [31:0] w);
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    r   = $random(seed);
    rd  = pick_reg($random(seed));
    rs1 = pick_reg($random(seed));
    rs2 = pick_reg($random(seed));
    case (r[3:0])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: w = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
      4'd6:       w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      4'd7, 4'd8: w = {r[31:20], rs1, 3'b000, rd, 7'b0010011};
      // Raw word that is nearly always an unsupported encoding
      4'd9:       w = $random(seed);
      default:    w = {7'b0000000, rs2, rs1, r[6:4], rd, 7'b0110011};
    endcase
  endtask

  // RV32 semantics in program order
  task automatic execute_model(input logic [31:0] w);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic        writes;
    rd     = w[11:7];
    rs1    = w[19:15];
    rs2    = w[24:20];
    a      = model_regs[rs1];
    b      = model_regs[rs2];
    imm    = {{20{w[31]}}, w[31:20]};
    res    = '0;
    writes = 1'b1;
    if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000000) begin
      case (w[14:12])
        3'd0:    res = a + b;
        3'd1:    res = a << b[4:0];
        3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd4:    res = a ^ b;
        3'd5:    res = a >> b[4:0];
        3'd6:    res = a | b;
        3'd7:    res = a & b;
        default: writes = 1'b0;
      endcase
    end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0100000 && w[14:12] == 3'd0) begin
      res = a - b;
    end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000001 && w[14:12] == 3'd0) begin
      res = a * b;
    end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'd0) begin
      res = a + imm;
    end else begin
      writes = 1'b0;
    end
    if (writes && rd != 5'd0) begin
      model_regs[rd]          = res;
      exp_mem[rd][q_tail[rd]] = res;
      q_tail[rd]++;
      outstanding++;
      expected_writes++;
    end
  endtask

  task automatic check_writeback();
    logic [4:0]  r;
    logic [31:0] exp;
    logic        have_exp;
    r = wb_reg_o;
    pulses++;
    assert (r != 5'd0) else begin
      other_errors++;
      $display("ERROR: %0t writeback reported for register x0", $time);
    end
    have_exp = (q_head[r] != q_tail[r]);
    assert (have_exp) else begin
      other_errors++;
      $display("ERROR: %0t writeback to x%0d with no write expected", $time, r);
    end
    if (have_exp) begin
      exp = exp_mem[r][q_head[r]];
      q_head[r]++;
      outstanding--;
      assert (wb_data_o === exp) else begin
        value_errors++;
        $display("FAIL %0t wb_data_o (x%0d) expected %h got %h", $time, r, exp, wb_data_o);
      end
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d (value %0d, other %0d), writebacks %0d of %0d expected",
             value_errors + other_errors, value_errors, other_errors, pulses, expected_writes);
    if (value_errors + other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // Sample mid-cycle where DUT outputs and driven inputs are settled
  always @(negedge clk_i) begin
    if (!rst_i || post_rst_cycles < 2) begin
      assert (wb_valid_o === 1'b0) else begin
        value_errors++;
        $display("FAIL %0t wb_valid_o expected 0 got %b", $time, wb_valid_o);
      end
      assert (stall_o === 1'b0) else begin
        value_errors++;
        $display("FAIL %0t stall_o expected 0 got %b", $time, stall_o);
      end
    end
    if (rst_i) begin
      post_rst_cycles++;
      if (wb_valid_o) begin
        check_writeback();
      end
      taken = instr_valid_i && !stall_o;
      if (taken) begin
        execute_model(instr_i);
      end
    end else begin
      taken = 1'b0;
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk_i);
    other_errors++;
    $display("ERROR: %0t run did not finish within %0d cycles", $time, WDOG_CYCLES);
    finish_run();
  end

  initial begin
    logic [31:0] r;
    logic        drive_done;
    seed            = 32'h4c9f;
    value_errors    = 0;
    other_errors    = 0;
    pulses          = 0;
    expected_writes = 0;
    outstanding     = 0;
    offered         = 0;
    post_rst_cycles = 0;
    taken           = 1'b0;
    drive_done      = 1'b0;
    for (int i = 0; i < `CPU_NUM_REGS; i++) begin
      model_regs[i] = '0;
      q_head[i]     = 0;
      q_tail[i]     = 0;
    end
    rst_i         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #STIM_DLY;
    rst_i = 1'b1;
    repeat (2) @(posedge clk_i);
    while (!drive_done) begin
      @(posedge clk_i);
      #STIM_DLY;
      // A stalled instruction stays on the input unchanged
      if (!instr_valid_i || taken) begin
        r = $random(seed);
        if (offered == NUM_INSTR) begin
          instr_valid_i = 1'b0;
          drive_done    = 1'b1;
        end else if (r[2:0] == 3'd0) begin
          instr_valid_i = 1'b0;
        end else begin
          make_instr(instr_i);
          instr_valid_i = 1'b1;
          offered++;
        end
      end
    end
    // Let the pipe drain
    for (int c = 0; c < DRAIN_CYCLES && outstanding != 0; c++) begin
      @(posedge clk_i);
    end
    // Room for a late or stray writeback to show up
    repeat (`CPU_MUL_STAGES + 4) @(posedge clk_i);
    assert (pulses == expected_writes) else begin
      other_errors++;
      $display("ERROR: %0d writebacks seen but %0d expected", pulses, expected_writes);
    end
    for (int i = 0; i < `CPU_NUM_REGS; i++) begin
      assert (q_head[i] == q_tail[i]) else begin
        other_errors++;
        $display("ERROR: x%0d still has %0d expected writes", i, q_tail[i] - q_head[i]);
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: writeback_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_settings.svh"

module writeback_regs (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [`CPU_REG_IDX_W-1:0] rs1_idx_i,
  input  logic [`CPU_REG_IDX_W-1:0] rs2_idx_i,
  input  logic                      alu_done_i,
  input  logic [`CPU_REG_IDX_W-1:0] alu_rd_i,
  input  logic [`CPU_DATA_W-1:0]    alu_result_i,
  input  logic                      mul_done_i,
  input  logic [`CPU_REG_IDX_W-1:0] mul_rd_i,
  input  logic [`CPU_DATA_W-1:0]    mul_result_i,
  output logic [`CPU_DATA_W-1:0]    rs1_data_o,
  output logic [`CPU_DATA_W-1:0]    rs2_data_o,
  output logic                      wb_valid_o,
  output logic [`CPU_REG_IDX_W-1:0] wb_reg_o,
  output logic [`CPU_DATA_W-1:0]    wb_data_o
);

  logic [`CPU_DATA_W-1:0]    regs_q [`CPU_NUM_REGS];
  logic                      wr_en;
  logic [`CPU_REG_IDX_W-1:0] wr_rd;
  logic [`CPU_DATA_W-1:0]    wr_data;

  // Multiply wins, issue keeps the two apart anyway
  assign wr_rd   = mul_done_i ? mul_rd_i : alu_rd_i;
  assign wr_data = mul_done_i ? mul_result_i : alu_result_i;
  assign wr_en   = (mul_done_i || alu_done_i) && (wr_rd != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_rd] <= wr_data;
    end
  end

  // Write-through of the register being written this cycle
  assign rs1_data_o = (wr_en && wr_rd == rs1_idx_i) ? wr_data : regs_q[rs1_idx_i];
  assign rs2_data_o = (wr_en && wr_rd == rs2_idx_i) ? wr_data : regs_q[rs2_idx_i];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= wr_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      wb_reg_o  <= wr_rd;
      wb_data_o <= wr_data;
    end
  end

endmodule

`default_nettype wire
